// ==== include/dma_config.svh ====
// DMA controller configuration
// Buffer depth, AXI id width and the data memory window

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Entries in the in-order command buffer
`define DMA_BUF_DEPTH 4

// AXI id width
`define DMA_TAG_W 4

// Data memory window, byte addressed
`define DMA_MEM_BASE 32'hF004_0000
`define DMA_MEM_SIZE 32'h0001_0000

`endif

// ==== rtl/dma_pkg.sv ====
// DMA controller shared types
// AXI payloads, arbitrated command, memory port and response codes

`include "dma_config.svh"

package dma_pkg;

   localparam int DMA_PTR_W = $clog2(`DMA_BUF_DEPTH);

   typedef logic [DMA_PTR_W-1:0] dma_ptr_t;   // Buffer entry index

   // ************************************************************************
   // AXI side payloads
   // ************************************************************************
   typedef struct packed {
      logic [`DMA_TAG_W-1:0] id;
      logic [31:0]           addr;
      logic [2:0]            size;
   } axi_aw_t;

   typedef struct packed {
      logic [63:0] data;
      logic [7:0]  strb;
   } axi_w_t;

   typedef struct packed {
      logic [`DMA_TAG_W-1:0] id;
      logic [31:0]           addr;
      logic [2:0]            size;
   } axi_ar_t;

   typedef struct packed {
      logic                  write;
      logic [31:0]           addr;
      logic [2:0]            size;
      logic [63:0]           wdata;
      logic [7:0]            byteen;
      logic [`DMA_TAG_W-1:0] tag;
   } bus_cmd_t;

   // ************************************************************************
   // Memory port payloads
   // ************************************************************************
   typedef struct packed {
      dma_ptr_t    tag;     // Entry number, echoed on read return
      logic [31:0] addr;
      logic [2:0]  size;
      logic        write;
      logic [63:0] wdata;
   } mem_req_t;

   typedef struct packed {
      dma_ptr_t    tag;
      logic        ecc_error;
      logic [63:0] rdata;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   typedef struct packed {
      logic any_err;     // Entry failed for any reason
      logic align_err;   // Slave error class (alignment or ECC)
   } dma_err_t;

endpackage

// ==== rtl/dma_wr_buffer.sv ====
// DMA write channel buffer
// Holds one AW and one W beat until the pair goes to the arbiter

`timescale 1ns/100ps

module dma_wr_buffer
   import dma_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    aw_valid,
   input  axi_aw_t aw,
   output logic    aw_ready,
   input  logic    w_valid,
   input  axi_w_t  w,
   output logic    w_ready,
   input  logic    sent,
   output logic    wr_valid,
   output axi_aw_t wr_aw,
   output axi_w_t  wr_w
);

   logic aw_vld, w_vld;
   logic aw_hs, w_hs;

   assign aw_ready = ~aw_vld | sent;   // Empty, or draining this cycle
   assign w_ready  = ~w_vld | sent;
   assign aw_hs    = aw_valid & aw_ready;
   assign w_hs     = w_valid & w_ready;
   assign wr_valid = aw_vld & w_vld;

   // Each half refills on its own handshake, else clears when the pair leaves
   always_ff @(posedge clk) begin
      if (reset) begin
         aw_vld <= 1'b0;
         w_vld  <= 1'b0;
      end else begin
         if (aw_hs)     aw_vld <= 1'b1;
         else if (sent) aw_vld <= 1'b0;
         if (w_hs)      w_vld <= 1'b1;
         else if (sent) w_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) wr_aw <= aw;
      if (w_hs)  wr_w  <= w;
   end

   a_sent_needs_pair: assert property (@(posedge clk) disable iff (reset) sent |-> wr_valid);

endmodule

// ==== rtl/dma_rd_buffer.sv ====
// DMA read channel buffer
// Holds one accepted AR until the arbiter sends it

`timescale 1ns/100ps

module dma_rd_buffer
   import dma_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    ar_valid,
   input  axi_ar_t ar,
   output logic    ar_ready,
   input  logic    sent,
   output logic    rd_valid,
   output axi_ar_t rd_ar
);

   logic ar_hs;

   assign ar_ready = ~rd_valid | sent;
   assign ar_hs    = ar_valid & ar_ready;

   always_ff @(posedge clk) begin
      if (reset)      rd_valid <= 1'b0;
      else if (ar_hs) rd_valid <= 1'b1;
      else if (sent)  rd_valid <= 1'b0;   // Sent with nothing new behind it
   end

   always_ff @(posedge clk) begin
      if (ar_hs) rd_ar <= ar;
   end

endmodule

// ==== rtl/dma_cmd_arbiter.sv ====
// Round-robin arbiter between the write and read channel buffers
// Builds one bus command stream for the DMA buffer

`timescale 1ns/100ps

module dma_cmd_arbiter
   import dma_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     wr_valid,
   input  axi_aw_t  wr_aw,
   input  axi_w_t   wr_w,
   input  logic     rd_valid,
   input  axi_ar_t  rd_ar,
   input  logic     cmd_ready,
   output logic     cmd_valid,
   output bus_cmd_t cmd,
   output logic     wr_sent,
   output logic     rd_sent
);

   logic wr_prio;   // Write wins a tie while set
   logic sel_wr;
   logic cmd_sent;

   assign sel_wr    = (wr_valid & rd_valid) ? wr_prio : wr_valid;
   assign cmd_valid = wr_valid | rd_valid;
   assign cmd_sent  = cmd_valid & cmd_ready;
   assign wr_sent   = cmd_sent & sel_wr;
   assign rd_sent   = cmd_sent & ~sel_wr;

   always_comb begin
      cmd.write  = sel_wr;
      cmd.addr   = sel_wr ? wr_aw.addr : rd_ar.addr;
      cmd.size   = sel_wr ? wr_aw.size : rd_ar.size;
      cmd.tag    = sel_wr ? wr_aw.id : rd_ar.id;
      cmd.wdata  = wr_w.data;
      cmd.byteen = sel_wr ? wr_w.strb : 8'h00;   // No lanes on reads
   end

   // Flip on every command taken
   always_ff @(posedge clk) begin
      if (reset)         wr_prio <= 1'b0;
      else if (cmd_sent) wr_prio <= ~wr_prio;
   end

   // A write pair that loses the cycle waits unchanged for its turn
   a_wr_held: assert property (@(posedge clk) disable iff (reset)
      wr_valid && !wr_sent |=> wr_valid && $stable(wr_aw) && $stable(wr_w));

endmodule

// ==== rtl/dma_access_check.sv ====
// DMA access checker for the head buffer entry
// Window and alignment rules, plus dword-to-word narrowing of writes

`timescale 1ns/100ps

`include "dma_config.svh"

module dma_access_check
   import dma_pkg::*;
(
   input  logic [31:0] addr,
   input  logic [2:0]  size,
   input  logic        write,
   input  logic [7:0]  byteen,
   output dma_err_t    err,
   output logic [31:0] mem_addr,
   output logic [2:0]  mem_size
);

   localparam logic [31:0] WIN_BASE = `DMA_MEM_BASE;
   localparam logic [31:0] WIN_SIZE = `DMA_MEM_SIZE;

   logic [31:0] win_offset;
   logic        addr_err;
   logic        mis_addr;
   logic [3:0]  word_lanes;
   logic        bad_wr;
   logic        half_wr;

   assign win_offset = addr - WIN_BASE;
   assign addr_err   = (addr < WIN_BASE) | (win_offset >= WIN_SIZE);

   always_comb begin
      case (size)
         3'd0:    mis_addr = 1'b0;
         3'd1:    mis_addr = addr[0];
         3'd2:    mis_addr = |addr[1:0];
         3'd3:    mis_addr = |addr[2:0];
         default: mis_addr = 1'b1;   // Wider than a dword
      endcase
   end

   assign word_lanes = addr[2] ? byteen[7:4] : byteen[3:0];

   // Writes are word or dword only, with full lanes
   assign bad_wr = write & ((size < 3'd2) |
                            ((size == 3'd2) & (word_lanes != 4'hf)) |
                            ((size == 3'd3) & ~((byteen == 8'h0f) | (byteen == 8'hf0) |
                                                (byteen == 8'hff))));

   assign err.any_err   = addr_err | mis_addr | bad_wr;
   assign err.align_err = ~addr_err & (mis_addr | bad_wr);

   // Half-filled dword write goes out as a word on the live half
   assign half_wr  = write & (size == 3'd3) & ((byteen == 8'h0f) | (byteen == 8'hf0));
   assign mem_size = half_wr ? 3'd2 : size;
   assign mem_addr = (half_wr & byteen[7]) ? {addr[31:3], 1'b1, addr[1:0]} : addr;

endmodule

// ==== rtl/dma_buffer.sv ====
// DMA in-order command buffer
// Issues entries to the memory port, collects read returns by tag, answers in order

`timescale 1ns/100ps

`include "dma_config.svh"

module dma_buffer
   import dma_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cmd_valid,
   input  bus_cmd_t              cmd,
   output logic                  cmd_ready,
   input  dma_err_t              err,
   input  logic [31:0]           chk_mem_addr,
   input  logic [2:0]            chk_mem_size,
   output logic [31:0]           head_addr,
   output logic [2:0]            head_size,
   output logic                  head_write,
   output logic [7:0]            head_byteen,
   output logic                  mem_req_valid,
   output mem_req_t              mem_req,
   input  logic                  mem_ready,
   input  logic                  mem_rsp_valid,
   input  mem_rsp_t              mem_rsp,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [`DMA_TAG_W-1:0] bid,
   output axi_resp_e             bresp,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [`DMA_TAG_W-1:0] rid,
   output logic [63:0]           rdata,
   output axi_resp_e             rresp,
   output logic                  active
);

   localparam int DEPTH = `DMA_BUF_DEPTH;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Entry state
   logic [DEPTH-1:0]     ent_valid, ent_pend, ent_done, ent_done_q;
   dma_err_t [DEPTH-1:0] ent_err;
   logic [31:0]          ent_addr   [DEPTH];
   logic [2:0]           ent_size   [DEPTH];
   logic [7:0]           ent_byteen [DEPTH];
   logic                 ent_write  [DEPTH];
   logic [`DMA_TAG_W-1:0] ent_tag   [DEPTH];
   logic [63:0]          ent_data   [DEPTH];

   dma_ptr_t   wr_ptr, iss_ptr, rsp_ptr;
   logic [CNT_W-1:0] num_valid;
   logic       cmd_en, head_live, err_en, mem_accept, rsp_valid, rsp_sent;
   logic [DEPTH-1:0] cap_en, iss_sel, rtn_en, free_en;
   axi_resp_e  rsp_code;

   function automatic dma_ptr_t next_ptr(input dma_ptr_t ptr);
      return (ptr == dma_ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_comb begin
      num_valid = '0;
      for (int i = 0; i < DEPTH; i++) begin
         num_valid = num_valid + CNT_W'(ent_valid[i]);
      end
   end

   assign cmd_ready = (num_valid < CNT_W'(DEPTH));
   assign cmd_en    = cmd_valid & cmd_ready;
   assign active    = |ent_valid;

   // ************************************************************************
   // Issue side
   // ************************************************************************
   assign head_addr   = ent_addr[iss_ptr];
   assign head_size   = ent_size[iss_ptr];
   assign head_write  = ent_write[iss_ptr];
   assign head_byteen = ent_byteen[iss_ptr];

   assign head_live     = ent_valid[iss_ptr] & ~ent_pend[iss_ptr] & ~ent_done[iss_ptr];
   assign err_en        = head_live & err.any_err;     // Retire without a request
   assign mem_req_valid = head_live & ~err.any_err;
   assign mem_accept    = mem_req_valid & mem_ready;

   assign mem_req.tag   = iss_ptr;
   assign mem_req.addr  = chk_mem_addr;
   assign mem_req.size  = chk_mem_size;
   assign mem_req.write = head_write;
   assign mem_req.wdata = ent_data[iss_ptr];

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         cap_en[i]  = cmd_en & (wr_ptr == dma_ptr_t'(i));
         iss_sel[i] = (iss_ptr == dma_ptr_t'(i));
         rtn_en[i]  = mem_rsp_valid & (mem_rsp.tag == dma_ptr_t'(i));
         free_en[i] = rsp_sent & (rsp_ptr == dma_ptr_t'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ent_valid  <= '0;
         ent_pend   <= '0;
         ent_done   <= '0;
         ent_done_q <= '0;
         ent_err    <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (free_en[i]) begin
               ent_valid[i]  <= 1'b0;
               ent_pend[i]   <= 1'b0;
               ent_done[i]   <= 1'b0;
               ent_done_q[i] <= 1'b0;
               ent_err[i]    <= '0;
            end else begin
               if (cap_en[i]) ent_valid[i] <= 1'b1;
               if (iss_sel[i] & mem_accept & ~head_write) ent_pend[i] <= 1'b1;
               if ((iss_sel[i] & (err_en | (mem_accept & head_write))) | rtn_en[i])
                  ent_done[i] <= 1'b1;
               ent_done_q[i] <= ent_done[i];   // Response one cycle after done
               if (iss_sel[i] & err_en)
                  ent_err[i] <= err;
               else if (rtn_en[i] & mem_rsp.ecc_error)
                  ent_err[i] <= '{any_err: 1'b1, align_err: 1'b1};
            end
         end
      end
   end

   // Payload, with the address standing in for data on any error
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (cap_en[i]) begin
            ent_addr[i]   <= cmd.addr;
            ent_size[i]   <= cmd.size;
            ent_byteen[i] <= cmd.byteen;
            ent_write[i]  <= cmd.write;
            ent_tag[i]    <= cmd.tag;
            ent_data[i]   <= cmd.wdata;
         end else if (iss_sel[i] & err_en) begin
            ent_data[i] <= {32'h0, ent_addr[i]};
         end else if (rtn_en[i]) begin
            ent_data[i] <= mem_rsp.ecc_error ? {32'h0, ent_addr[i]} : mem_rsp.rdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr  <= '0;
         iss_ptr <= '0;
         rsp_ptr <= '0;
      end else begin
         if (cmd_en)              wr_ptr  <= next_ptr(wr_ptr);
         if (mem_accept | err_en) iss_ptr <= next_ptr(iss_ptr);
         if (rsp_sent)            rsp_ptr <= next_ptr(rsp_ptr);
      end
   end

   // ************************************************************************
   // Response side
   // ************************************************************************
   assign rsp_valid = ent_valid[rsp_ptr] & ent_done_q[rsp_ptr];
   assign rsp_code  = ent_err[rsp_ptr].align_err ? SLVERR :
                      ent_err[rsp_ptr].any_err   ? DECERR : OKAY;

   assign bvalid   = rsp_valid & ent_write[rsp_ptr];
   assign bid      = ent_tag[rsp_ptr];
   assign bresp    = rsp_code;
   assign rvalid   = rsp_valid & ~ent_write[rsp_ptr];
   assign rid      = ent_tag[rsp_ptr];
   assign rdata    = ent_data[rsp_ptr];
   assign rresp    = rsp_code;
   assign rsp_sent = (bvalid & bready) | (rvalid & rready);

   a_done_is_valid: assert property (@(posedge clk) disable iff (reset)
      (ent_done & ~ent_valid) == '0);

   a_b_held: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp));

endmodule

// ==== rtl/dma_ctrl.sv ====
// DMA slave controller top level
// AXI write/read channel buffers, arbiter, access check and in-order buffer

`timescale 1ns/100ps

`include "dma_config.svh"

module dma_ctrl
   import dma_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   // AXI write
   input  logic                  aw_valid,
   input  axi_aw_t               aw,
   output logic                  aw_ready,
   input  logic                  w_valid,
   input  axi_w_t                w,
   output logic                  w_ready,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [`DMA_TAG_W-1:0] bid,
   output axi_resp_e             bresp,
   // AXI read
   input  logic                  ar_valid,
   input  axi_ar_t               ar,
   output logic                  ar_ready,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [`DMA_TAG_W-1:0] rid,
   output logic [63:0]           rdata,
   output axi_resp_e             rresp,
   // Memory port
   output logic                  mem_req_valid,
   output mem_req_t              mem_req,
   input  logic                  mem_ready,
   input  logic                  mem_rsp_valid,
   input  mem_rsp_t              mem_rsp,
   output logic                  dma_active
);

   logic        wr_valid, rd_valid, wr_sent, rd_sent;
   axi_aw_t     wr_aw;
   axi_w_t      wr_w;
   axi_ar_t     rd_ar;
   logic        cmd_valid, cmd_ready;
   bus_cmd_t    cmd;
   dma_err_t    chk_err;
   logic [31:0] chk_mem_addr, head_addr;
   logic [2:0]  chk_mem_size, head_size;
   logic        head_write, buf_active;
   logic [7:0]  head_byteen;

   dma_wr_buffer u_wr_buf (
      .clk, .reset, .aw_valid, .aw, .aw_ready, .w_valid, .w, .w_ready,
      .sent(wr_sent), .wr_valid, .wr_aw, .wr_w
   );

   dma_rd_buffer u_rd_buf (
      .clk, .reset, .ar_valid, .ar, .ar_ready,
      .sent(rd_sent), .rd_valid, .rd_ar
   );

   dma_cmd_arbiter u_arb (
      .clk, .reset, .wr_valid, .wr_aw, .wr_w, .rd_valid, .rd_ar,
      .cmd_ready, .cmd_valid, .cmd, .wr_sent, .rd_sent
   );

   dma_access_check u_chk (
      .addr(head_addr), .size(head_size), .write(head_write), .byteen(head_byteen),
      .err(chk_err), .mem_addr(chk_mem_addr), .mem_size(chk_mem_size)
   );

   dma_buffer u_buf (
      .clk, .reset, .cmd_valid, .cmd, .cmd_ready,
      .err(chk_err), .chk_mem_addr, .chk_mem_size,
      .head_addr, .head_size, .head_write, .head_byteen,
      .mem_req_valid, .mem_req, .mem_ready, .mem_rsp_valid, .mem_rsp,
      .bvalid, .bready, .bid, .bresp, .rvalid, .rready, .rid, .rdata, .rresp,
      .active(buf_active)
   );

   assign dma_active = buf_active | wr_valid | rd_valid;

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source
// 4 ns clock, synchronous reset held for the first 3 cycles

`timescale 1ns/100ps

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// ==== tb/tb_mem_model.sv ====
// Behavioral data memory for the DMA testbench
// Random request ready, reads returned by tag after random latency, ECC error window

`timescale 1ns/100ps

`include "dma_config.svh"

module tb_mem_model
   import dma_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     mem_req_valid,
   input  mem_req_t mem_req,
   output logic     mem_ready,
   output logic     mem_rsp_valid,
   output mem_rsp_t mem_rsp
);

   localparam logic [31:0] ECC_LO = `DMA_MEM_BASE + 32'h0000_ff00;   // Top 256 bytes flag ECC

   logic [7:0]  mem [logic [31:0]];
   logic        pend_vld  [8];
   dma_ptr_t    pend_tag  [8];
   logic [63:0] pend_data [8];
   logic        pend_ecc  [8];
   int          pend_wait [8];

   function automatic logic [7:0] fill_byte(input logic [31:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
   endfunction

   function automatic logic [7:0] rd_byte(input logic [31:0] a);
      return mem.exists(a) ? mem[a] : fill_byte(a);
   endfunction

   initial begin
      mem_ready     = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp       = '0;
      for (int i = 0; i < 8; i++) pend_vld[i] = 1'b0;
   end

   always @(posedge clk) begin
      logic        sent;
      logic [31:0] a;
      logic [31:0] base;
      sent = 1'b0;
      mem_rsp_valid <= 1'b0;
      // Return at most one finished read per cycle
      for (int i = 0; i < 8; i++) begin
         if (pend_vld[i] && pend_wait[i] == 0 && !sent) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp <= '{tag: pend_tag[i], ecc_error: pend_ecc[i], rdata: pend_data[i]};
            pend_vld[i] = 1'b0;
            sent = 1'b1;
         end else if (pend_vld[i] && pend_wait[i] > 0) begin
            pend_wait[i] = pend_wait[i] - 1;
         end
      end
      if (!reset && mem_req_valid && mem_ready) begin
         if (mem_req.write) begin
            for (int k = 0; k < (1 << mem_req.size); k++) begin
               a = mem_req.addr + k;
               mem[a] = mem_req.wdata[8*a[2:0] +: 8];   // Lane follows the address
            end
         end else begin
            for (int i = 0; i < 8; i++) begin
               if (!pend_vld[i]) begin
                  base = {mem_req.addr[31:3], 3'b000};
                  pend_vld[i]  = 1'b1;
                  pend_tag[i]  = mem_req.tag;
                  pend_ecc[i]  = (mem_req.addr >= ECC_LO) &&
                                 (mem_req.addr < `DMA_MEM_BASE + `DMA_MEM_SIZE);
                  pend_wait[i] = $urandom % 6;
                  for (int k = 0; k < 8; k++) pend_data[i][8*k +: 8] = rd_byte(base + k);
                  break;
               end
            end
         end
      end
      mem_ready <= ($urandom % 4) != 0;
   end

endmodule

// ==== tb/dma_ctrl_tb.sv ====
// DMA slave controller testbench
// Directed and random AXI traffic, in-order response checks against a byte reference

`timescale 1ns/100ps

`include "dma_config.svh"

module dma_ctrl_tb
   import dma_pkg::*;
();

   localparam logic [31:0] BASE = `DMA_MEM_BASE;
   localparam int N_RAND    = 24;
   localparam int N_BACK    = 32;
   localparam int N_CMDS    = 8 + 2 * N_RAND + N_BACK;
   localparam int MAX_CYCLE = 40 * N_CMDS + 200;

   logic clk, reset;
   logic aw_valid, w_valid, ar_valid, bready, rready;
   axi_aw_t aw;
   axi_w_t  w;
   axi_ar_t ar;
   logic aw_ready, w_ready, ar_ready, bvalid, rvalid, dma_active;
   logic [`DMA_TAG_W-1:0] bid, rid;
   logic [63:0] rdata;
   axi_resp_e bresp, rresp;
   logic mem_req_valid, mem_ready, mem_rsp_valid;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;

   // Expected responses per channel in handshake order
   logic [`DMA_TAG_W-1:0] eb_id [128];
   axi_resp_e             eb_resp [128];
   logic [`DMA_TAG_W-1:0] er_id [128];
   axi_resp_e             er_resp [128];
   logic [63:0]           er_data [128];
   int b_wr, b_rd, r_wr, r_rd;
   logic b_take, r_take;
   logic [7:0] ref_mem [logic [31:0]];

   int    err_count;
   int    cycles;
   string test_name;
   logic  chk_f0, chk_no_req;
   logic [31:0] f0_addr;

   tb_clock_gen u_clk (.clk, .reset);

   tb_mem_model u_mem (.clk, .reset, .mem_req_valid, .mem_req, .mem_ready,
                       .mem_rsp_valid, .mem_rsp);

   dma_ctrl DUT (.*);

   function automatic logic [7:0] fill_byte(input logic [31:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
   endfunction

   function automatic logic [63:0] ref_dword(input logic [31:0] a);
      logic [63:0] d;
      for (int k = 0; k < 8; k++) d[8*k +: 8] = ref_mem.exists(a + k) ? ref_mem[a + k] :
                                                fill_byte(a + k);
      return d;
   endfunction

   // ************************************************************************
   // Command drivers
   // ************************************************************************
   task automatic axi_write(input logic [3:0] id, input logic [31:0] addr,
                            input logic [2:0] size, input logic [63:0] data,
                            input logic [7:0] strb, input axi_resp_e resp);
      logic aw_done, w_done, aw_hs, w_hs;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge clk);
      aw_valid <= 1'b1;
      aw       <= '{id: id, addr: addr, size: size};
      w_valid  <= 1'b1;
      w        <= '{data: data, strb: strb};
      while (!(aw_done && w_done)) begin
         @(negedge clk);
         aw_hs = aw_valid && aw_ready;
         w_hs  = w_valid && w_ready;
         @(posedge clk);
         if (aw_hs) begin
            aw_done = 1'b1;
            aw_valid <= 1'b0;
         end
         if (w_hs) begin
            w_done = 1'b1;
            w_valid <= 1'b0;
         end
      end
      eb_id[b_wr % 128]   = id;
      eb_resp[b_wr % 128] = resp;
      b_wr = b_wr + 1;
      if (resp == OKAY) begin
         for (int k = 0; k < 8; k++)
            if (strb[k]) ref_mem[{addr[31:3], 3'b000} + k] = data[8*k +: 8];
      end
   endtask

   task automatic axi_read(input logic [3:0] id, input logic [31:0] addr,
                           input logic [2:0] size, input axi_resp_e resp);
      logic hs;
      hs = 1'b0;
      @(posedge clk);
      ar_valid <= 1'b1;
      ar       <= '{id: id, addr: addr, size: size};
      while (!hs) begin
         @(negedge clk);
         hs = ar_valid && ar_ready;
         @(posedge clk);
      end
      ar_valid <= 1'b0;
      er_id[r_wr % 128]   = id;
      er_resp[r_wr % 128] = resp;
      er_data[r_wr % 128] = (resp == OKAY) ? ref_dword(addr) : {32'h0, addr};
      r_wr = r_wr + 1;
   endtask

   task automatic wait_drain();
      while (b_rd != b_wr || r_rd != r_wr) @(negedge clk);
   endtask

   // Response handshakes sampled mid-cycle where the outputs are settled
   always @(negedge clk) begin
      b_take <= bvalid && bready;
      r_take <= rvalid && rready;
   end

   always @(posedge clk) begin
      if (b_take) b_rd <= b_rd + 1;
      if (r_take) r_rd <= r_rd + 1;
      bready <= ($urandom % 3) != 0;
      rready <= ($urandom % 3) != 0;
   end

   // ************************************************************************
   // Checks
   // ************************************************************************
   a_reset_idle: assert property (@(posedge clk) $fell(reset) |->
      !bvalid && !rvalid && !mem_req_valid && !dma_active && aw_ready && w_ready && ar_ready)
      else begin
         err_count++;
         $display("Outputs not idle right after reset");
      end

   a_active: assert property (@(posedge clk) disable iff (reset)
      (bvalid || rvalid || mem_req_valid) |-> dma_active)
      else begin
         err_count++;
         $display("dma_active low while a command is in flight in %s", test_name);
      end

   a_b_expected: assert property (@(posedge clk) disable iff (reset) bvalid |-> b_rd != b_wr)
      else begin
         err_count++;
         $display("Write response with no command outstanding in %s", test_name);
      end

   a_r_expected: assert property (@(posedge clk) disable iff (reset) rvalid |-> r_rd != r_wr)
      else begin
         err_count++;
         $display("Read response with no command outstanding in %s", test_name);
      end

   a_bid: assert property (@(posedge clk) disable iff (reset) bvalid |-> bid == eb_id[b_rd % 128])
      else begin
         err_count++;
         $display("ERR %s bid expected %0h actual %0h", test_name,
                  eb_id[$sampled(b_rd) % 128], $sampled(bid));
      end

   a_bresp: assert property (@(posedge clk) disable iff (reset)
      bvalid |-> bresp == eb_resp[b_rd % 128])
      else begin
         err_count++;
         $display("ERR %s bresp expected %0h actual %0h", test_name,
                  eb_resp[$sampled(b_rd) % 128], $sampled(bresp));
      end

   a_rid: assert property (@(posedge clk) disable iff (reset) rvalid |-> rid == er_id[r_rd % 128])
      else begin
         err_count++;
         $display("ERR %s rid expected %0h actual %0h", test_name,
                  er_id[$sampled(r_rd) % 128], $sampled(rid));
      end

   a_rresp: assert property (@(posedge clk) disable iff (reset)
      rvalid |-> rresp == er_resp[r_rd % 128])
      else begin
         err_count++;
         $display("ERR %s rresp expected %0h actual %0h", test_name,
                  er_resp[$sampled(r_rd) % 128], $sampled(rresp));
      end

   a_rdata: assert property (@(posedge clk) disable iff (reset)
      rvalid |-> rdata == er_data[r_rd % 128])
      else begin
         err_count++;
         $display("ERR %s rdata expected %h actual %h", test_name,
                  er_data[$sampled(r_rd) % 128], $sampled(rdata));
      end

   a_b_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
      else begin
         err_count++;
         $display("Write response changed before bready in %s", test_name);
      end

   a_r_hold: assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rresp))
      else begin
         err_count++;
         $display("Read response changed before rready in %s", test_name);
      end

   a_narrow: assert property (@(posedge clk) disable iff (reset)
      chk_f0 && mem_req_valid && mem_req.write |-> mem_req.size == 3'd2 &&
      mem_req.addr == f0_addr)
      else begin
         err_count++;
         $display("ERR %s mem size/addr expected %0d/%h actual %0d/%h", test_name, 3'd2,
                  f0_addr, $sampled(mem_req.size), $sampled(mem_req.addr));
      end

   a_no_req: assert property (@(posedge clk) disable iff (reset) chk_no_req |-> !mem_req_valid)
      else begin
         err_count++;
         $display("Memory request seen for a rejected write in %s", test_name);
      end

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLE) begin
         $display("Timeout after %0d cycles in %s", cycles, test_name);
         $display("Some tests failed");
         $finish;
      end
   end

   // ************************************************************************
   // Stimulus
   // ************************************************************************
   initial begin
      void'($urandom(32'hbcbd1dd6));
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      ar_valid <= 1'b0;
      aw <= '0;
      w  <= '0;
      ar <= '0;
      bready <= 1'b0;
      rready <= 1'b0;
      b_wr = 0;
      b_rd = 0;
      r_wr = 0;
      r_rd = 0;
      b_take = 1'b0;
      r_take = 1'b0;
      err_count = 0;
      cycles = 0;
      chk_f0 = 1'b0;
      chk_no_req = 1'b0;
      f0_addr = '0;
      test_name = "reset";
      @(negedge reset);
      repeat (2) @(posedge clk);

      test_name = "write_read";
      axi_write(4'h3, BASE + 32'h10, 3'd3, 64'h0123_4567_89ab_cdef, 8'hff, OKAY);
      axi_read(4'h9, BASE + 32'h10, 3'd3, OKAY);
      wait_drain();

      test_name = "narrow_f0";
      f0_addr = BASE + 32'h44;
      chk_f0 = 1'b1;
      axi_write(4'h5, BASE + 32'h40, 3'd3, 64'h1122_3344_5566_7788, 8'hf0, OKAY);
      wait_drain();
      chk_f0 = 1'b0;
      axi_read(4'h6, BASE + 32'h40, 3'd3, OKAY);
      wait_drain();

      test_name = "bad_strobe";
      chk_no_req = 1'b1;
      axi_write(4'h7, BASE + 32'h20, 3'd2, 64'h0, 8'h07, SLVERR);
      wait_drain();
      chk_no_req = 1'b0;

      test_name = "errors";
      axi_read(4'h1, 32'h1000_0010, 3'd3, DECERR);
      axi_read(4'h2, BASE + 32'h101, 3'd1, SLVERR);
      axi_read(4'h4, BASE + 32'hff08, 3'd3, SLVERR);
      wait_drain();

      test_name = "random_mix";
      fork
         begin
            logic [7:0] strb;
            repeat (N_RAND) begin
               case ($urandom % 3)
                  0:       strb = 8'h0f;
                  1:       strb = 8'hf0;
                  default: strb = 8'hff;
               endcase
               axi_write(4'($urandom), BASE + 8 * ($urandom % N_BACK), 3'd3,
                         {$urandom, $urandom}, strb, OKAY);
               repeat ($urandom % 3) @(posedge clk);
            end
         end
         begin
            repeat (N_RAND) begin
               axi_read(4'($urandom), BASE + 32'h8000 + 8 * ($urandom % 64), 3'd3, OKAY);
               repeat ($urandom % 3) @(posedge clk);
            end
         end
      join
      wait_drain();

      test_name = "readback";
      for (int i = 0; i < N_BACK; i++) axi_read(4'(i), BASE + 8 * i, 3'd3, OKAY);
      wait_drain();
      repeat (4) @(posedge clk);

      $display("Responses checked: %0d write, %0d read; errors: %0d", b_rd, r_rd, err_count);
      if (err_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+include
rtl/dma_pkg.sv
rtl/dma_wr_buffer.sv
rtl/dma_rd_buffer.sv
rtl/dma_cmd_arbiter.sv
rtl/dma_access_check.sv
rtl/dma_buffer.sv
rtl/dma_ctrl.sv
tb/tb_clock_gen.sv
tb/tb_mem_model.sv
tb/dma_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DMA controller testbench with Verilator

set -u
cd "$(dirname "$0")"

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module dma_ctrl_tb -o dma_ctrl_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see $BUILD_LOG"
   exit 1
fi

./obj_dir/dma_ctrl_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
   exit 1
fi
if ! grep -q "All tests passed" "$SIM_LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0
